// File: Makefile
BIN = obj_dir/Vtb_mips_exec_slice

.PHONY: all run clean

all: run

$(BIN): build.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_mips_exec_slice -f build.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: build.f
mips_isa_pkg.sv
exec_pkg.sv
mips_decoder.sv
mips_alu.sv
writeback_select.sv
regfile.sv
mips_exec_slice.sv
mips_exec_props.sv
tb_mips_exec_slice.sv

// File: exec_golden.txt
// Line 1 holds the vector count; then per vector, in hex:
// last_of_group instr pc mem_rdata exp_wb_valid exp_wb_addr exp_wb_data exp_v0
23
0 24011234 00000000 00000000 1 01 00001234 00000000
0 3C038000 00000000 00000000 1 03 80000000 00000000
0 3424F0F0 00000000 00000000 1 04 0000F2F4 00000000
0 2865FFFF 00000000 00000000 1 05 00000001 00000000
0 3886FFFF 00000000 00000000 1 06 00000D0B 00000000
1 30870FF0 00000000 00000000 1 07 000002F0 00000000
0 00244023 00000000 00000000 1 08 FFFF1F40 00000000
0 0061482A 00000000 00000000 1 09 00000001 00000000
0 0061502B 00000000 00000000 1 0A 00000000 00000000
0 00035903 00000000 00000000 1 0B F8000000 00000000
0 00036102 00000000 00000000 1 0C 08000000 00000000
0 00016A00 00000000 00000000 1 0D 00123400 00000000
0 00817024 00000000 00000000 1 0E 00001234 00000000
0 00817826 00000000 00000000 1 0F 0000E0C0 00000000
1 00618025 00000000 00000000 1 10 80001234 00000000
0 24020005 00000000 00000000 1 02 00000005 00000005
1 00421021 00000000 00000000 1 02 0000000A 0000000A
0 80110001 00000000 11F23344 1 11 FFFFFFF2 0000000A
0 90120001 00000000 11F23344 1 12 000000F2 0000000A
0 84130002 00000000 12348765 1 13 FFFF8765 0000000A
0 94140000 00000000 87651234 1 14 00008765 0000000A
1 8C150004 00000000 DEADBEEF 1 15 DEADBEEF 0000000A
0 88160001 00000000 AABBCCDD 1 16 BBCCDD00 0000000A
0 98160002 00000000 AABBCCDD 1 16 BBAABBCC 0000000A
0 88160003 00000000 AABBCCDD 1 16 DDAABBCC 0000000A
0 98160000 00000000 AABBCCDD 1 16 DDAABBAA 0000000A
0 88160002 00000000 AABBCCDD 1 16 CCDDBBAA 0000000A
1 98160003 00000000 AABBCCDD 1 16 AABBCCDD 0000000A
0 0C000100 00400010 00000000 1 1F 00400018 0000000A
1 03E0B809 00400100 00000000 1 17 00400108 0000000A
0 24200007 00000000 00000000 1 00 0000123B 0000000A
0 34180055 00000000 00000000 1 18 00000055 0000000A
0 AC020000 00000000 00000000 0 00 00000000 0000000A
0 00000018 00000000 00000000 0 00 00000000 0000000A
1 24420001 00000000 00000000 1 02 0000000B 0000000B

// File: exec_pkg.sv
/* Execution slice definitions: write-back and load kinds, ALU operations
   and register-file constants */
`default_nettype none

package exec_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // JAL destination
    localparam logic [REG_ADDR_W-1:0] V0_REG   = 5'd2;

    // Return address skips the branch delay slot
    localparam logic [DATA_W-1:0] LINK_OFFSET = 32'd8;

    // Source of the value written back one cycle after the strobe
    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_kind_t;

    typedef enum logic [2:0] {
        LD_W,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_WL,
        LD_WR
    } load_kind_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, LUI
    } alu_op_t;

endpackage

`default_nettype wire

// File: mips_alu.sv
/* 32-bit ALU: add, subtract, logic, set-less-than, shifts and LUI */
`default_nettype none
`timescale 1ns/100ps

module mips_alu (
    input  exec_pkg::alu_op_t            op,
    input  logic [exec_pkg::DATA_W-1:0]  a,
    input  logic [exec_pkg::DATA_W-1:0]  b,
    input  logic [4:0]                   shamt,
    output logic [exec_pkg::DATA_W-1:0]  result
);

    always_comb begin
        result = '0;
        case (op)
            exec_pkg::ADD:  result = a + b;     // Wraps, no overflow trap
            exec_pkg::SUB:  result = a - b;
            exec_pkg::AND:  result = a & b;
            exec_pkg::OR:   result = a | b;
            exec_pkg::XOR:  result = a ^ b;
            exec_pkg::SLT:  result[0] = $signed(a) < $signed(b);
            exec_pkg::SLTU: result[0] = a < b;

            // Shifts act on rt, which arrives on b
            exec_pkg::SLL:  result = b << shamt;
            exec_pkg::SRL:  result = b >> shamt;
            exec_pkg::SRA:  result = $unsigned($signed(b) >>> shamt);

            exec_pkg::LUI:  result = {b[15:0], 16'h0000};
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_decoder.sv
/* Instruction decoder: operand selects, ALU operation, destination
   register and write-back kind */
`default_nettype none
`timescale 1ns/100ps

module mips_decoder (
    input  mips_isa_pkg::instr_word_t          instr,
    output exec_pkg::alu_op_t                  alu_op,
    output logic                               use_imm,
    output logic                               imm_sign,
    output exec_pkg::wb_kind_t                 wb_kind,
    output exec_pkg::load_kind_t               load_kind,
    output logic [exec_pkg::REG_ADDR_W-1:0]    dest
);

    always_comb begin
        // Defaults describe an instruction that writes nothing
        alu_op    = exec_pkg::ADD;
        use_imm   = 1'b0;
        imm_sign  = 1'b0;
        wb_kind   = exec_pkg::WB_NONE;
        load_kind = exec_pkg::LD_W;
        dest      = instr.i.rt;           // Immediates and loads target rt

        case (instr.r.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                dest    = instr.r.rd;
                wb_kind = exec_pkg::WB_ALU;
                case (instr.r.funct)
                    mips_isa_pkg::FN_ADDU: alu_op = exec_pkg::ADD;
                    mips_isa_pkg::FN_SUBU: alu_op = exec_pkg::SUB;
                    mips_isa_pkg::FN_AND:  alu_op = exec_pkg::AND;
                    mips_isa_pkg::FN_OR:   alu_op = exec_pkg::OR;
                    mips_isa_pkg::FN_XOR:  alu_op = exec_pkg::XOR;
                    mips_isa_pkg::FN_SLT:  alu_op = exec_pkg::SLT;
                    mips_isa_pkg::FN_SLTU: alu_op = exec_pkg::SLTU;
                    mips_isa_pkg::FN_SLL:  alu_op = exec_pkg::SLL;
                    mips_isa_pkg::FN_SRL:  alu_op = exec_pkg::SRL;
                    mips_isa_pkg::FN_SRA:  alu_op = exec_pkg::SRA;
                    mips_isa_pkg::FN_JALR: wb_kind = exec_pkg::WB_LINK; // Link into rd
                    default:               wb_kind = exec_pkg::WB_NONE;
                endcase
            end

            mips_isa_pkg::OP_JAL: begin
                wb_kind = exec_pkg::WB_LINK;
                dest    = exec_pkg::LINK_REG;
            end

            // Arithmetic immediates are sign-extended, logic ones are not
            mips_isa_pkg::OP_ADDIU,
            mips_isa_pkg::OP_SLTI: begin
                use_imm  = 1'b1;
                imm_sign = 1'b1;
                wb_kind  = exec_pkg::WB_ALU;
                alu_op   = (instr.r.opcode == mips_isa_pkg::OP_SLTI) ? exec_pkg::SLT
                                                                    : exec_pkg::ADD;
            end

            mips_isa_pkg::OP_ANDI,
            mips_isa_pkg::OP_ORI,
            mips_isa_pkg::OP_XORI,
            mips_isa_pkg::OP_LUI: begin
                use_imm = 1'b1;
                wb_kind = exec_pkg::WB_ALU;
                case (instr.r.opcode)
                    mips_isa_pkg::OP_ANDI: alu_op = exec_pkg::AND;
                    mips_isa_pkg::OP_ORI:  alu_op = exec_pkg::OR;
                    mips_isa_pkg::OP_XORI: alu_op = exec_pkg::XOR;
                    default:               alu_op = exec_pkg::LUI;
                endcase
            end

            // Loads compute rs + sext(imm16) as the memory address
            mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LBU,
            mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LHU,
            mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LWL,
            mips_isa_pkg::OP_LWR: begin
                use_imm  = 1'b1;
                imm_sign = 1'b1;
                wb_kind  = exec_pkg::WB_LOAD;
                case (instr.r.opcode)
                    mips_isa_pkg::OP_LB:  load_kind = exec_pkg::LD_B;
                    mips_isa_pkg::OP_LBU: load_kind = exec_pkg::LD_BU;
                    mips_isa_pkg::OP_LH:  load_kind = exec_pkg::LD_H;
                    mips_isa_pkg::OP_LHU: load_kind = exec_pkg::LD_HU;
                    mips_isa_pkg::OP_LWL: load_kind = exec_pkg::LD_WL;
                    mips_isa_pkg::OP_LWR: load_kind = exec_pkg::LD_WR;
                    default:              load_kind = exec_pkg::LD_W;
                endcase
            end

            default: wb_kind = exec_pkg::WB_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_exec_props.sv
/* Concurrent assertions on the write-back valid rules and register zero,
   bound into the write-back select and the register file */
`default_nettype none
`timescale 1ns/100ps

module mips_exec_props #(
    parameter bit WB_RULES  = 1'b0,
    parameter bit REG_RULES = 1'b0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        strobe,
    input  logic        wb_valid,
    input  logic [4:0]  addr_a,
    input  logic [31:0] data_a,
    input  logic [4:0]  addr_b,
    input  logic [31:0] data_b
);

    // Nothing is written back in the cycle after a reset cycle
    wb_low_after_reset: assert property (@(posedge clk) (rst && WB_RULES) |=> !wb_valid)
        else $error("wb_valid high right after reset");

    wb_follows_strobe: assert property (@(posedge clk) disable iff (rst || !WB_RULES)
        wb_valid |-> $past(strobe))
        else $error("wb_valid without a strobe one cycle earlier");

    // Both read ports return zero for register 0
    r0_reads_zero: assert property (@(posedge clk) disable iff (!REG_RULES)
        ((addr_a != 5'd0) || (data_a == 32'd0)) && ((addr_b != 5'd0) || (data_b == 32'd0)))
        else $error("register 0 read as nonzero");

endmodule

bind writeback_select mips_exec_props #(.WB_RULES(1'b1)) i_wb_props (
    .clk(clk), .rst(rst), .strobe(instr_valid), .wb_valid(wb_valid),
    .addr_a(5'd1), .data_a(32'd0), .addr_b(5'd1), .data_b(32'd0)
);

bind regfile mips_exec_props #(.REG_RULES(1'b1)) i_reg_props (
    .clk(clk), .rst(rst), .strobe(1'b0), .wb_valid(wb_valid),
    .addr_a(addr_rs), .data_a(read_data_1), .addr_b(addr_rt), .data_b(read_data_2)
);

`default_nettype wire

// File: mips_exec_slice.sv
/* Operand and write-back slice top: decoder, register file, ALU and
   write-back select */
`default_nettype none
`timescale 1ns/100ps

module mips_exec_slice (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               instr_valid,
    input  logic [31:0]                        instr,
    input  logic [exec_pkg::DATA_W-1:0]        pc,
    input  logic [exec_pkg::DATA_W-1:0]        mem_rdata,
    output logic [exec_pkg::DATA_W-1:0]        mem_addr,
    output logic                               wb_valid,
    output logic [exec_pkg::REG_ADDR_W-1:0]    wb_addr,
    output logic [exec_pkg::DATA_W-1:0]        wb_data,
    output logic [exec_pkg::DATA_W-1:0]        v0
);

    mips_isa_pkg::instr_word_t          instr_w;
    exec_pkg::alu_op_t                  alu_op;
    exec_pkg::wb_kind_t                 wb_kind;
    exec_pkg::load_kind_t               load_kind;
    logic                               use_imm;
    logic                               imm_sign;
    logic [exec_pkg::REG_ADDR_W-1:0]    dest;
    logic [exec_pkg::DATA_W-1:0]        rs_value;
    logic [exec_pkg::DATA_W-1:0]        rt_value;
    logic [exec_pkg::DATA_W-1:0]        operand_b;
    logic [exec_pkg::DATA_W-1:0]        alu_result;
    logic [3:0]                         wb_byteen;

    assign instr_w = instr;

    mips_decoder i_decoder (
        .instr     (instr_w),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .imm_sign  (imm_sign),
        .wb_kind   (wb_kind),
        .load_kind (load_kind),
        .dest      (dest)
    );

    regfile i_regfile (
        .clk         (clk),
        .rst         (rst),
        .addr_rs     (instr_w.r.rs),
        .addr_rt     (instr_w.r.rt),
        .read_data_1 (rs_value),
        .read_data_2 (rt_value),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_byteen   (wb_byteen),
        .wb_data     (wb_data),
        .v0          (v0)
    );

    // Operand B is rt or the extended 16-bit immediate
    assign operand_b = !use_imm ? rt_value
                     : imm_sign ? {{16{instr_w.i.imm16[15]}}, instr_w.i.imm16}
                                : {16'h0000, instr_w.i.imm16};

    mips_alu i_alu (
        .op     (alu_op),
        .a      (rs_value),
        .b      (operand_b),
        .shamt  (instr_w.r.shamt),
        .result (alu_result)
    );

    assign mem_addr = alu_result;   // Loads use rs + sext(imm16)

    writeback_select i_wb_select (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .wb_kind_in  (wb_kind),
        .load_kind   (load_kind),
        .dest        (dest),
        .alu_result  (alu_result),
        .pc          (pc),
        .rt_value    (rt_value),
        .mem_rdata   (mem_rdata),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_byteen   (wb_byteen),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: mips_isa_pkg.sv
/* MIPS instruction encodings: opcode and function codes, and the
   instruction word union with its R-type and I-type views */
`default_nettype none

package mips_isa_pkg;

    // ########################################################################
    // Primary opcodes, instr[31:26]
    // ########################################################################
    localparam logic [5:0] OP_SPECIAL = 6'h00; // R-type, decoded by funct
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LWL     = 6'h22;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_LWR     = 6'h26;

    // ########################################################################
    // Function codes for OP_SPECIAL, instr[5:0]
    // ########################################################################
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // Register-format view of the word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // Immediate-format view, also used by the loads
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    // The opcode picks which view is meaningful
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_t;

endpackage

`default_nettype wire

// File: regfile.sv
/* Register file: 32 x 32-bit, two read ports with write bypass,
   byte-enabled write port and a v0 tap */
`default_nettype none
`timescale 1ns/100ps

module regfile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [exec_pkg::REG_ADDR_W-1:0]    addr_rs,
    input  logic [exec_pkg::REG_ADDR_W-1:0]    addr_rt,
    output logic [exec_pkg::DATA_W-1:0]        read_data_1,
    output logic [exec_pkg::DATA_W-1:0]        read_data_2,
    input  logic                               wb_valid,
    input  logic [exec_pkg::REG_ADDR_W-1:0]    wb_addr,
    input  logic [3:0]                         wb_byteen,
    input  logic [exec_pkg::DATA_W-1:0]        wb_data,
    output logic [exec_pkg::DATA_W-1:0]        v0
);

    logic [exec_pkg::DATA_W-1:0] regs [32];
    logic [exec_pkg::DATA_W-1:0] merged;   // Target register after the byte write
    logic                        wr_en;

    // Disabled bytes keep their current contents
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = wb_byteen[i] ? wb_data[8*i +: 8] : regs[wb_addr][8*i +: 8];
        end
    end

    assign wr_en = wb_valid && (wb_addr != '0);

    // A read of the register being written sees the new word this cycle
    function automatic logic [exec_pkg::DATA_W-1:0] read_port(
        input logic [exec_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wr_en && addr == wb_addr) begin
            return merged;
        end
        return regs[addr];
    endfunction

    always_comb begin
        read_data_1 = read_port(addr_rs);
        read_data_2 = read_port(addr_rt);
    end

    assign v0 = regs[exec_pkg::V0_REG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr] <= merged;
        end
    end

endmodule

`default_nettype wire

// File: tb_mips_exec_slice.sv
/* Testbench: replays golden vectors through the slice, acts as the
   one-cycle memory and checks write-back and v0 */
`default_nettype none
`timescale 1ns/100ps

module tb_mips_exec_slice;

    localparam int PERIOD  = 40;
    localparam int MAX_VEC = 64;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] mem_rdata;
    logic [31:0] mem_addr;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic [31:0] v0;

    // Word 0 is the vector count, then 8 words per vector
    logic [31:0] gold [0:8*MAX_VEC];
    int          nvec;
    int          errors = 0;
    int          failed_tests = 0;
    bit          vec_bad [MAX_VEC];

    // Expected register contents, built from the golden write-backs
    logic [31:0] reg_model [32];

    mips_exec_slice i_mips_exec_slice (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .mem_rdata(mem_rdata), .mem_addr(mem_addr), .wb_valid(wb_valid),
        .wb_addr(wb_addr), .wb_data(wb_data), .v0(v0)
    );

    always #(PERIOD/2) clk = ~clk;

    // Fields: 0 last of group, 1 instr, 2 pc, 3 mem word, 4 valid, 5 addr, 6 data, 7 v0
    function automatic logic [31:0] vec_field(input int k, input int j);
        return gold[1 + 8*k + j];
    endfunction

    task automatic compare_writeback(input int k);
        logic [31:0] exp_valid;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        exp_valid = vec_field(k, 4);
        exp_addr  = vec_field(k, 5);
        exp_data  = vec_field(k, 6);
        if (wb_valid !== exp_valid[0]) begin
            $display("CHECK FAILED at %0t: vector %0d wb_valid %b, expected %b",
                     $time, k, wb_valid, exp_valid[0]);
            errors++;
            vec_bad[k] = 1'b1;
        end
        if (exp_valid[0] && (wb_addr !== exp_addr[4:0])) begin
            $display("CHECK FAILED at %0t: vector %0d wb_addr %0d, expected %0d",
                     $time, k, wb_addr, exp_addr[4:0]);
            errors++;
            vec_bad[k] = 1'b1;
        end
        if (exp_valid[0] && (wb_data !== exp_data)) begin
            $display("CHECK FAILED at %0t: vector %0d wb_data %h, expected %h",
                     $time, k, wb_data, exp_data);
            errors++;
            vec_bad[k] = 1'b1;
        end
    endtask

    task automatic close_vector(input int k);
        if (v0 !== vec_field(k, 7)) begin
            $display("CHECK FAILED at %0t: vector %0d v0 %h, expected %h",
                     $time, k, v0, vec_field(k, 7));
            errors++;
            vec_bad[k] = 1'b1;
        end
        if (vec_bad[k]) failed_tests++;
        $display("vector %0d instr %h: %s", k, vec_field(k, 1), vec_bad[k] ? "failed" : "ok");
    endtask

    // Loads show rs + sext(imm16) on mem_addr in the strobe cycle
    task automatic verify_load_address(input int k);
        logic [31:0] word;
        logic [31:0] exp_addr;
        logic [31:0] exp_valid;
        logic [31:0] dest;
        word      = vec_field(k, 1);
        exp_addr  = reg_model[word[25:21]] + {{16{word[15]}}, word[15:0]};
        exp_valid = vec_field(k, 4);
        dest      = vec_field(k, 5);
        if ((word[31:29] == 3'b100) && (mem_addr !== exp_addr)) begin
            $display("CHECK FAILED at %0t: vector %0d mem_addr %h, expected %h",
                     $time, k, mem_addr, exp_addr);
            errors++;
            vec_bad[k] = 1'b1;
        end
        // Later vectors read the register as this write-back leaves it
        if (exp_valid[0] && (dest[4:0] != 5'd0)) begin
            reg_model[dest[4:0]] = vec_field(k, 6);
        end
    endtask

    // ########################################################################
    // Watchdog, sized from the vector count
    // ########################################################################
    initial begin
        #1;
        #((nvec * 4 + 40) * PERIOD);
        $display("Timeout: the vectors did not complete in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ########################################################################
    // Stimulus and checking
    // ########################################################################
    initial begin
        logic [31:0] group_end;
        int issued;
        int in_wb;
        int v0_idx;
        int idle;
        int i;

        rst         <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= 32'h0;
        pc          <= 32'h0;
        mem_rdata   <= 32'h0;
        for (int r = 0; r < 32; r++) begin
            reg_model[r] = 32'h0;
        end
        void'($urandom(90));
        $readmemh("exec_golden.txt", gold);
        nvec = int'(gold[0]);
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        issued = -1;
        in_wb  = -1;
        idle   = 0;
        i      = 0;
        while (i < nvec || issued >= 0 || in_wb >= 0) begin
            @(posedge clk);
            v0_idx = in_wb;
            in_wb  = issued;
            issued = -1;
            mem_rdata <= (in_wb >= 0) ? vec_field(in_wb, 3) : 32'h0; // Memory answers next cycle
            if (i < nvec && idle == 0) begin
                instr_valid <= 1'b1;
                instr       <= vec_field(i, 1);
                pc          <= vec_field(i, 2);
                issued = i;
                group_end = vec_field(i, 0);
                if (group_end[0]) idle = 1 + int'($urandom % 3); // Gap after a group
                i++;
            end else begin
                instr_valid <= 1'b0;
                if (idle > 0) idle--;
            end
            @(negedge clk);
            if (in_wb >= 0) compare_writeback(in_wb);
            if (v0_idx >= 0) close_vector(v0_idx);
            if (issued >= 0) verify_load_address(issued);
        end

        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 nvec, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: writeback_select.sv
/* Write-back stage register with load alignment: builds the write
   address, data word and byte enables one cycle after the strobe */
`default_nettype none
`timescale 1ns/100ps

module writeback_select (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               instr_valid,
    input  exec_pkg::wb_kind_t                 wb_kind_in,
    input  exec_pkg::load_kind_t               load_kind,
    input  logic [exec_pkg::REG_ADDR_W-1:0]    dest,
    input  logic [exec_pkg::DATA_W-1:0]        alu_result,
    input  logic [exec_pkg::DATA_W-1:0]        pc,
    input  logic [exec_pkg::DATA_W-1:0]        rt_value,
    input  logic [exec_pkg::DATA_W-1:0]        mem_rdata,
    output logic                               wb_valid,
    output logic [exec_pkg::REG_ADDR_W-1:0]    wb_addr,
    output logic [3:0]                         wb_byteen,
    output logic [exec_pkg::DATA_W-1:0]        wb_data
);

    logic                             valid_q;
    exec_pkg::wb_kind_t               kind_q;
    exec_pkg::load_kind_t             load_q;
    logic [exec_pkg::DATA_W-1:0]      alu_q;
    logic [exec_pkg::DATA_W-1:0]      link_q;
    logic [exec_pkg::DATA_W-1:0]      rt_q;   // Old rt value, fills LWL/LWR gaps
    logic [1:0]                       off_q;  // Byte offset of the load address
    logic [7:0]                       ld_byte;
    logic [15:0]                      ld_half;
    logic [exec_pkg::DATA_W-1:0]      shifted;

    // ########################################################################
    // Capture at the strobe
    // ########################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid && (wb_kind_in != exec_pkg::WB_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            kind_q  <= wb_kind_in;
            load_q  <= load_kind;
            wb_addr <= dest;
            alu_q   <= alu_result;
            link_q  <= pc + exec_pkg::LINK_OFFSET;
            rt_q    <= rt_value;
            off_q   <= alu_result[1:0];
        end
    end

    assign wb_valid = valid_q;

    // ########################################################################
    // Big-endian alignment of the memory word
    // ########################################################################
    assign ld_byte = mem_rdata[{~off_q, 3'b000} +: 8];     // Offset 0 is bits 31:24
    assign ld_half = mem_rdata[{~off_q[1], 4'b0000} +: 16];

    // LWL moves the addressed byte to the top, LWR moves it to the bottom
    assign shifted = (load_q == exec_pkg::LD_WL) ? mem_rdata << {off_q, 3'b000}
                                                  : mem_rdata >> {~off_q, 3'b000};

    always_comb begin
        wb_byteen = 4'b1111;
        wb_data   = alu_q;
        case (kind_q)
            exec_pkg::WB_LINK: wb_data = link_q;
            exec_pkg::WB_LOAD: begin
                case (load_q)
                    exec_pkg::LD_B:  wb_data = {{24{ld_byte[7]}}, ld_byte};
                    exec_pkg::LD_BU: wb_data = {24'h000000, ld_byte};
                    exec_pkg::LD_H:  wb_data = {{16{ld_half[15]}}, ld_half};
                    exec_pkg::LD_HU: wb_data = {16'h0000, ld_half};
                    exec_pkg::LD_WL: wb_byteen = 4'b1111 << off_q;     // 1111 .. 1000
                    exec_pkg::LD_WR: wb_byteen = 4'b1111 >> ~off_q;    // 0001 .. 1111
                    default:         wb_data = mem_rdata;
                endcase
                // Partial loads keep the untouched bytes of rt in the data word
                if (load_q == exec_pkg::LD_WL || load_q == exec_pkg::LD_WR) begin
                    for (int i = 0; i < 4; i++) begin
                        wb_data[8*i +: 8] = wb_byteen[i] ? shifted[8*i +: 8]
                                                         : rt_q[8*i +: 8];
                    end
                end
            end
            default: wb_data = alu_q;
        endcase
    end

endmodule

`default_nettype wire
